// ==== verilog/mmio_pkg.sv ====
package mmio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // address map, selected by dmem_addr[29:26]
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [3:0] REGION_VMEM   = 4'hc;
    localparam logic [3:0] REGION_DEBUG  = 4'hd;
    localparam logic [3:0] REGION_KBD    = 4'he;
    localparam logic [3:0] REGION_LOADER = 4'hf;

    // compared against dmem_addr[25:18] inside the debug region
    localparam logic [7:0] TRAP_TAG   = 8'hdd;
    localparam logic [7:0] STATUS_TAG = 8'h01;

    // status word offsets, dmem_addr[17:0]
    localparam logic [17:0] STAT_WPTR  = 18'd0;
    localparam logic [17:0] STAT_COUNT = 18'd1;

    ////////////////////////////////////////////////////////////////////////////
    // memory sizes
    ////////////////////////////////////////////////////////////////////////////
    localparam int LOADER_WORDS = 256;
    localparam int TEXT_BYTES   = 4096;
    localparam int STORE_WORDS  = 1024;
    localparam int TRACE_DEPTH  = 32;

    localparam int LOADER_AW = $clog2(LOADER_WORDS);
    localparam int TEXT_AW   = $clog2(TEXT_BYTES);
    localparam int STORE_AW  = $clog2(STORE_WORDS);
    localparam int TRACE_AW  = $clog2(TRACE_DEPTH);

    localparam int TRACE_COUNT_W = 16;
    localparam int TRACE_ADDR_W  = 24;

    // character write holds the pipeline this many cycles
    localparam logic [1:0] VMEM_STALL_CYCLES = 2'd3;

    // nonzero start value for the store latency lfsr
    localparam logic [7:0] LFSR_SEED = 8'ha5;

    typedef struct packed {
        logic                    write;
        logic [TRACE_ADDR_W-1:0] addr;
    } trace_entry_t;

endpackage

// ==== verilog/mem_req_if.sv ====
`timescale 1ns/1ps

// four-phase req/ack link from the router to the data store
interface mem_req_if;

    logic        req;
    logic        write;
    logic [29:0] addr;
    logic [31:0] wdata;
    logic [3:0]  byte_en;
    logic        ack;
    logic [31:0] rdata;

    modport router (
        output req, write, addr, wdata, byte_en,
        input  ack, rdata
    );

    modport store (
        input  req, write, addr, wdata, byte_en,
        output ack, rdata
    );

endinterface

// ==== verilog/bus_router.sv ====
`timescale 1ns/1ps

module bus_router import mmio_pkg::*; (
    input  logic                     cache_stall,
    input  logic                     rst,
    input  logic                     dmem_read,
    input  logic                     dmem_write,
    input  logic [29:0]              dmem_addr,
    input  logic [31:0]              wdata,
    input  logic [3:0]               byte_en,
    input  logic [31:0]              text_rdata,
    input  logic                     text_stall,
    input  logic [31:0]              loader_rdata,
    input  trace_entry_t             trace_rdata,
    input  logic [TRACE_AW-1:0]      trace_wptr,
    input  logic [TRACE_COUNT_W-1:0] trace_count,
    output logic [31:0]              rdata,
    output logic                     mem_stall,
    output logic                     trap,
    output logic                     text_wen,
    output logic                     loader_wen,
    output logic [TRACE_AW-1:0]      trace_index,
    output logic                     record,
    output trace_entry_t             record_entry,
    mem_req_if.router                bus
);

    logic [3:0]  region;
    logic [7:0]  tag;
    logic [17:0] offset;
    logic        access;
    logic        store_sel;
    logic        req_q;

    assign region = dmem_addr[29:26];
    assign tag    = dmem_addr[25:18];
    assign offset = dmem_addr[17:0];
    assign access = dmem_read | dmem_write;

    // everything below hex c goes to the data store
    assign store_sel  = access && (region < REGION_VMEM);
    assign text_wen   = dmem_write && (region == REGION_VMEM);
    assign loader_wen = dmem_write && (region == REGION_LOADER);
    assign trap       = access && (region == REGION_DEBUG) && (tag == TRAP_TAG);

    assign trace_index = dmem_addr[TRACE_AW-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // router side of the four-phase handshake
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            req_q <= 1'b0;
        end else if (req_q && bus.ack) begin
            req_q <= 1'b0;
        end else if (store_sel && !req_q && !bus.ack) begin
            // previous ack must be gone before a new request
            req_q <= 1'b1;
        end
    end

    assign bus.req     = req_q;
    assign bus.write   = dmem_write;
    assign bus.addr    = dmem_addr;
    assign bus.wdata   = wdata;
    assign bus.byte_en = byte_en;

    // completing edge of a store access
    assign record       = req_q && bus.ack;
    assign record_entry = '{write: dmem_write, addr: dmem_addr[TRACE_ADDR_W-1:0]};

    assign mem_stall = text_stall | trap | (store_sel && !(req_q && bus.ack));

    always_comb begin
        rdata = bus.rdata;
        case (region)
            REGION_VMEM:   rdata = text_rdata;
            REGION_KBD:    rdata = '0;
            REGION_LOADER: rdata = loader_rdata;
            REGION_DEBUG: begin
                if (tag == TRAP_TAG) begin
                    rdata = '0;
                end else if (tag == STATUS_TAG) begin
                    if (offset == STAT_WPTR) begin
                        rdata = 32'(trace_wptr);
                    end else if (offset == STAT_COUNT) begin
                        rdata = 32'(trace_count);
                    end else begin
                        rdata = '0;
                    end
                end else begin
                    rdata = 32'(trace_rdata);
                end
            end
            default:       rdata = bus.rdata;
        endcase
    end

    a_req_waits_ack: assert property (@(posedge cache_stall) disable iff (!rst)
        $rose(bus.req) |-> !$past(bus.ack));

    a_trap_stalls: assert property (@(posedge cache_stall) disable iff (!rst)
        trap |-> mem_stall);

endmodule

// ==== verilog/text_mem.sv ====
`timescale 1ns/1ps

module text_mem import mmio_pkg::*; (
    input  logic               cache_stall,
    input  logic               rst,
    input  logic               wen,
    input  logic [TEXT_AW-3:0] word_addr,
    input  logic [3:0]         byte_en,
    input  logic [31:0]        wdata,
    output logic [31:0]        rdata,
    output logic               stall
);

    logic [7:0]         text_ram [TEXT_BYTES];
    logic [1:0]         count;
    logic [1:0]         lane;
    logic [TEXT_AW-1:0] byte_addr;
    logic [7:0]         char_data;

    // one-hot lane select, lane 0 is the low byte
    always_comb begin
        case (byte_en)
            4'b0010: lane = 2'd1;
            4'b0100: lane = 2'd2;
            4'b1000: lane = 2'd3;
            default: lane = 2'd0;
        endcase
    end

    assign byte_addr = {word_addr, lane};
    assign char_data = wdata[{lane, 3'b000} +: 8];

    // write sequencer: 0, 1, 2, then spin on 3 for the completing edge
    always_ff @(posedge cache_stall) begin
        if (!rst || !wen) begin
            count <= 2'd0;
        end else if (count == VMEM_STALL_CYCLES) begin
            count <= 2'd0;
        end else begin
            count <= count + 2'd1;
        end
    end

    always_ff @(posedge cache_stall) begin
        if (wen && (count == VMEM_STALL_CYCLES - 2'd1)) begin
            text_ram[byte_addr] <= char_data;
        end
    end

    assign stall = wen && (count < VMEM_STALL_CYCLES);

    assign rdata = {text_ram[{word_addr, 2'd3}], text_ram[{word_addr, 2'd2}],
                    text_ram[{word_addr, 2'd1}], text_ram[{word_addr, 2'd0}]};

    a_char_lane_onehot: assert property (@(posedge cache_stall) disable iff (!rst)
        wen |-> $onehot(byte_en));

endmodule

// ==== verilog/loader_mem.sv ====
`timescale 1ns/1ps

module loader_mem import mmio_pkg::*; (
    input  logic                 cache_stall,
    input  logic [LOADER_AW-1:0] data_addr,
    input  logic [31:0]          wdata,
    input  logic                 wen,
    input  logic [LOADER_AW-1:0] instr_addr,
    output logic [31:0]          data_rdata,
    output logic [31:0]          instr_rdata
);

    logic [31:0] loader_ram [LOADER_WORDS];

    ////////////////////////////////////////////////////////////////////////////
    // data port, whole-word writes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge cache_stall) begin
        if (wen) begin
            loader_ram[data_addr] <= wdata;
        end
    end

    assign data_rdata = loader_ram[data_addr];

    // instruction fetch port is read only
    assign instr_rdata = loader_ram[instr_addr];

endmodule

// ==== verilog/data_store.sv ====
`timescale 1ns/1ps

module data_store import mmio_pkg::*; (
    input  logic     cache_stall,
    input  logic     rst,
    mem_req_if.store bus
);

    logic [31:0]         store_ram [STORE_WORDS];
    logic [STORE_AW-1:0] idx;
    logic [7:0]          lfsr;
    logic [1:0]          lat_cnt;
    logic                ack_q;
    logic                fire;
    logic [31:0]         rdata_q;

    assign idx = bus.addr[STORE_AW-1:0];

    // last latency cycle of an open request
    assign fire = bus.req && !ack_q && (lat_cnt == 2'd0);

    ////////////////////////////////////////////////////////////////////////////
    // store side of the handshake
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            ack_q   <= 1'b0;
            lat_cnt <= 2'd0;
            lfsr    <= LFSR_SEED;
        end else if (ack_q) begin
            if (!bus.req) begin
                ack_q <= 1'b0;
            end
        end else if (bus.req) begin
            if (fire) begin
                ack_q <= 1'b1;
                // x^8 + x^6 + x^5 + x^4 + 1
                lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end else begin
                lat_cnt <= lat_cnt - 2'd1;
            end
        end else begin
            // preload 0..3, giving 1 to 4 cycles once req shows up
            lat_cnt <= lfsr[1:0];
        end
    end

    always_ff @(posedge cache_stall) begin
        if (fire) begin
            if (bus.write) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (bus.byte_en[lane]) begin
                        store_ram[idx][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
                    end
                end
            end
            rdata_q <= store_ram[idx];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    a_ack_needs_req: assert property (@(posedge cache_stall) disable iff (!rst)
        $rose(bus.ack) |-> $past(bus.req));

endmodule

// ==== verilog/trace_queue.sv ====
`timescale 1ns/1ps

module trace_queue import mmio_pkg::*; (
    input  logic                     cache_stall,
    input  logic                     rst,
    input  logic                     record,
    input  trace_entry_t             entry,
    input  logic [TRACE_AW-1:0]      read_index,
    output trace_entry_t             read_entry,
    output logic [TRACE_AW-1:0]      wptr,
    output logic [TRACE_COUNT_W-1:0] count
);

    trace_entry_t trace_ram [TRACE_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // ring pointer and access counter
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            wptr  <= '0;
            count <= '0;
        end else if (record) begin
            // both wrap naturally at their width
            wptr  <= wptr + 1'b1;
            count <= count + 1'b1;
        end
    end

    // oldest entry is overwritten once the ring is full
    always_ff @(posedge cache_stall) begin
        if (record) begin
            trace_ram[wptr] <= entry;
        end
    end

    assign read_entry = trace_ram[read_index];

endmodule

// ==== verilog/mmio_top.sv ====
`timescale 1ns/1ps

module mmio_top import mmio_pkg::*; (
    input  logic        cache_stall,
    input  logic        rst,
    input  logic [29:0] instr_addr,
    input  logic        dmem_read,
    input  logic        dmem_write,
    input  logic [29:0] dmem_addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  byte_en,
    output logic [31:0] instr_data,
    output logic [31:0] rdata,
    output logic        mem_stall,
    output logic        trap
);

    logic [31:0]              text_rdata;
    logic                     text_stall;
    logic                     text_wen;
    logic [31:0]              loader_rdata;
    logic                     loader_wen;
    trace_entry_t             trace_rdata;
    logic [TRACE_AW-1:0]      trace_wptr;
    logic [TRACE_COUNT_W-1:0] trace_count;
    logic [TRACE_AW-1:0]      trace_index;
    logic                     record;
    trace_entry_t             record_entry;

    mem_req_if u_store_bus ();

    bus_router u_bus_router (
        .cache_stall  (cache_stall),
        .rst          (rst),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_addr    (dmem_addr),
        .wdata        (wdata),
        .byte_en      (byte_en),
        .text_rdata   (text_rdata),
        .text_stall   (text_stall),
        .loader_rdata (loader_rdata),
        .trace_rdata  (trace_rdata),
        .trace_wptr   (trace_wptr),
        .trace_count  (trace_count),
        .rdata        (rdata),
        .mem_stall    (mem_stall),
        .trap         (trap),
        .text_wen     (text_wen),
        .loader_wen   (loader_wen),
        .trace_index  (trace_index),
        .record       (record),
        .record_entry (record_entry),
        .bus          (u_store_bus.router)
    );

    text_mem u_text_mem (
        .cache_stall (cache_stall),
        .rst         (rst),
        .wen         (text_wen),
        .word_addr   (dmem_addr[TEXT_AW-3:0]),
        .byte_en     (byte_en),
        .wdata       (wdata),
        .rdata       (text_rdata),
        .stall       (text_stall)
    );

    // instruction port ignores the region bits
    loader_mem u_loader_mem (
        .cache_stall (cache_stall),
        .data_addr   (dmem_addr[LOADER_AW-1:0]),
        .wdata       (wdata),
        .wen         (loader_wen),
        .instr_addr  (instr_addr[LOADER_AW-1:0]),
        .data_rdata  (loader_rdata),
        .instr_rdata (instr_data)
    );

    data_store u_data_store (
        .cache_stall (cache_stall),
        .rst         (rst),
        .bus         (u_store_bus.store)
    );

    trace_queue u_trace_queue (
        .cache_stall (cache_stall),
        .rst         (rst),
        .record      (record),
        .entry       (record_entry),
        .read_index  (trace_index),
        .read_entry  (trace_rdata),
        .wptr        (trace_wptr),
        .count       (trace_count)
    );

endmodule

// ==== test/mmio_checker.sv ====
`timescale 1ns/1ps

module mmio_checker import mmio_pkg::*; (
    input  logic        cache_stall,
    input  logic        rst,
    input  logic [29:0] instr_addr,
    input  logic        dmem_read,
    input  logic        dmem_write,
    input  logic [29:0] dmem_addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  byte_en,
    input  logic [31:0] instr_data,
    input  logic [31:0] rdata,
    input  logic        mem_stall,
    input  logic        trap,
    output int          check_count,
    output int          error_count
);

    // reference model of every memory behind the router
    logic [31:0]              store_model  [STORE_WORDS];
    logic [31:0]              loader_model [LOADER_WORDS];
    bit                       loader_known [LOADER_WORDS];
    logic [7:0]               text_model   [TEXT_BYTES];
    bit                       text_known   [TEXT_BYTES];
    bit                       trace_write  [TRACE_DEPTH];
    logic [TRACE_ADDR_W-1:0]  trace_addr   [TRACE_DEPTH];
    bit                       trace_known  [TRACE_DEPTH];
    logic [TRACE_COUNT_W-1:0] access_count;
    int                       stall_cycles;

    logic [3:0]  region;
    logic [7:0]  tag;
    logic [17:0] offset;
    logic        in_trap;

    assign region  = dmem_addr[29:26];
    assign tag     = dmem_addr[25:18];
    assign offset  = dmem_addr[17:0];
    assign in_trap = (dmem_read || dmem_write) && (region == REGION_DEBUG) && (tag == TRAP_TAG);

    initial begin
        check_count  = 0;
        error_count  = 0;
        access_count = '0;
        stall_cycles = 0;
        // never-written store words read as zero
        for (int i = 0; i < STORE_WORDS; i++) begin
            store_model[i] = '0;
        end
        for (int i = 0; i < LOADER_WORDS; i++) begin
            loader_known[i] = 1'b0;
        end
        for (int i = 0; i < TEXT_BYTES; i++) begin
            text_known[i] = 1'b0;
        end
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            trace_known[i] = 1'b0;
        end
    end

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // model update on a completing edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic finish_access();
        logic [31:0]        expected;
        logic [TEXT_AW-1:0] byte_addr;
        logic [1:0]         lane;
        logic               known;
        int                 idx;
        int                 slot;
        if (region < REGION_VMEM) begin
            idx = int'(dmem_addr[STORE_AW-1:0]);
            if (stall_cycles == 0) begin
                error_count++;
                $display("store access to %h completed without any stall", dmem_addr);
            end
            if (dmem_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b]) begin
                        store_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
                    end
                end
            end else begin
                check_val("store_read", store_model[idx], rdata);
            end
            // ring slot is the count modulo the depth
            slot = int'(access_count) % TRACE_DEPTH;
            trace_write[slot] = dmem_write;
            trace_addr[slot]  = dmem_addr[TRACE_ADDR_W-1:0];
            trace_known[slot] = 1'b1;
            access_count      = access_count + 16'd1;
        end else if (region == REGION_VMEM) begin
            if (dmem_write) begin
                check_val("text_write_stall", 32'(VMEM_STALL_CYCLES), 32'(stall_cycles));
                lane = 2'd0;
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b]) begin
                        lane = 2'(b);
                    end
                end
                byte_addr = {dmem_addr[TEXT_AW-3:0], lane};
                text_model[byte_addr] = wdata[{lane, 3'b000} +: 8];
                text_known[byte_addr] = 1'b1;
            end else begin
                check_val("text_read_stall", 32'd0, 32'(stall_cycles));
                expected = '0;
                known = 1'b1;
                for (int b = 0; b < 4; b++) begin
                    byte_addr = {dmem_addr[TEXT_AW-3:0], 2'(b)};
                    expected[b*8 +: 8] = text_model[byte_addr];
                    known = known && text_known[byte_addr];
                end
                if (known) begin
                    check_val("text_read", expected, rdata);
                end
            end
        end else if (region == REGION_LOADER) begin
            check_val("loader_stall", 32'd0, 32'(stall_cycles));
            idx = int'(dmem_addr[LOADER_AW-1:0]);
            if (dmem_write) begin
                loader_model[idx] = wdata;
                loader_known[idx] = 1'b1;
            end else if (loader_known[idx]) begin
                check_val("loader_read", loader_model[idx], rdata);
            end
        end else if (region == REGION_KBD) begin
            check_val("kbd_stall", 32'd0, 32'(stall_cycles));
            if (dmem_read) begin
                check_val("kbd_read", 32'd0, rdata);
            end
        end else begin
            check_val("debug_stall", 32'd0, 32'(stall_cycles));
            if (dmem_read && tag == STATUS_TAG) begin
                if (offset == STAT_WPTR) begin
                    check_val("stat_wptr", 32'(int'(access_count) % TRACE_DEPTH), rdata);
                end else if (offset == STAT_COUNT) begin
                    check_val("stat_count", 32'(access_count), rdata);
                end else begin
                    check_val("stat_other", 32'd0, rdata);
                end
            end else if (dmem_read) begin
                idx = int'(dmem_addr[TRACE_AW-1:0]);
                if (trace_known[idx]) begin
                    check_val("trace_entry", {7'd0, trace_write[idx], trace_addr[idx]}, rdata);
                end
            end
        end
    endtask

    // outputs are compared before this edge's model update
    always @(posedge cache_stall) begin
        if (!rst) begin
            access_count = '0;
            stall_cycles = 0;
        end else begin
            if (loader_known[instr_addr[LOADER_AW-1:0]]) begin
                check_val("instr_fetch", loader_model[instr_addr[LOADER_AW-1:0]], instr_data);
            end
            if (dmem_read || dmem_write) begin
                check_val("trap_flag", 32'(in_trap), 32'(trap));
                if (mem_stall) begin
                    stall_cycles++;
                end else begin
                    if (in_trap) begin
                        check_val("trap_stall", 32'd1, 32'(mem_stall));
                    end else begin
                        finish_access();
                    end
                    stall_cycles = 0;
                end
            end else begin
                check_val("idle_stall", 32'd0, 32'(mem_stall));
                check_val("idle_trap", 32'd0, 32'(trap));
                stall_cycles = 0;
            end
        end
    end

endmodule

// ==== test/tb_mmio.sv ====
`timescale 1ns/1ps

module tb_mmio import mmio_pkg::*; ();

    localparam int SEED_INIT     = 24229;
    localparam int STALL_TIMEOUT = 50;
    localparam int RANDOM_OPS    = 2000;

    logic        cache_stall;
    logic        rst;
    logic [29:0] instr_addr;
    logic        dmem_read;
    logic        dmem_write;
    logic [29:0] dmem_addr;
    logic [31:0] wdata;
    logic [3:0]  byte_en;
    logic [31:0] instr_data;
    logic [31:0] rdata;
    logic        mem_stall;
    logic        trap;

    integer seed;
    int     timeout_count;
    int     check_count;
    int     error_count;

    mmio_top u_mmio_top (
        .cache_stall (cache_stall),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .dmem_read   (dmem_read),
        .dmem_write  (dmem_write),
        .dmem_addr   (dmem_addr),
        .wdata       (wdata),
        .byte_en     (byte_en),
        .instr_data  (instr_data),
        .rdata       (rdata),
        .mem_stall   (mem_stall),
        .trap        (trap)
    );

    mmio_checker u_mmio_checker (
        .cache_stall (cache_stall),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .dmem_read   (dmem_read),
        .dmem_write  (dmem_write),
        .dmem_addr   (dmem_addr),
        .wdata       (wdata),
        .byte_en     (byte_en),
        .instr_data  (instr_data),
        .rdata       (rdata),
        .mem_stall   (mem_stall),
        .trap        (trap),
        .check_count (check_count),
        .error_count (error_count)
    );

    initial begin
        cache_stall = 1'b0;
        forever #20 cache_stall = ~cache_stall;
    end

    // fetches stay inside the 32 loader words that get preloaded
    function automatic logic [29:0] pick_instr_addr();
        return {22'($random(seed)), 3'd0, 5'($random(seed))};
    endfunction

    task automatic drive_cpu(input logic rd, input logic wr, input logic [29:0] addr,
                             input logic [31:0] data, input logic [3:0] be);
        dmem_read  = rd;
        dmem_write = wr;
        dmem_addr  = addr;
        wdata      = data;
        byte_en    = be;
        instr_addr = pick_instr_addr();
    endtask

    task automatic idle_cycle();
        @(negedge cache_stall);
        drive_cpu(1'b0, 1'b0, dmem_addr, wdata, byte_en);
    endtask

    // hold the access until an edge with mem_stall low
    task automatic run_access(input logic wr, input logic [29:0] addr,
                              input logic [31:0] data, input logic [3:0] be);
        int   waited;
        logic done;
        if (timeout_count != 0) begin
            return;
        end
        @(negedge cache_stall);
        drive_cpu(!wr, wr, addr, data, be);
        waited = 0;
        done   = 1'b0;
        while (!done && waited < STALL_TIMEOUT) begin
            @(posedge cache_stall);
            done = !mem_stall;
            waited++;
        end
        if (!done) begin
            timeout_count++;
            $display("timeout: access to %h still stalled after %0d cycles", addr, waited);
        end
    endtask

    task automatic hold_trap(input logic wr, input logic [29:0] addr, input int cycles);
        @(negedge cache_stall);
        drive_cpu(!wr, wr, addr, 32'($random(seed)), 4'hf);
        for (int n = 0; n < cycles; n++) begin
            @(posedge cache_stall);
        end
        idle_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // preload so later reads always hit written data
    ////////////////////////////////////////////////////////////////////////////
    task automatic preload();
        for (int w = 0; w < 64; w++) begin
            run_access(1'b1, {4'(w % 12), 16'($random(seed)), 4'd0, 6'(w)},
                       32'($random(seed)), 4'hf);
        end
        for (int w = 0; w < 32; w++) begin
            run_access(1'b1, {REGION_LOADER, 18'($random(seed)), 3'd0, 5'(w)},
                       32'($random(seed)), 4'hf);
        end
        for (int w = 0; w < 64; w++) begin
            run_access(1'b1, {REGION_VMEM, 16'($random(seed)), 6'd0, 4'(w / 4)},
                       32'($random(seed)), 4'b0001 << (w % 4));
        end
    endtask

    task automatic random_access();
        int          kind;
        logic        wr;
        logic [7:0]  tag;
        logic [29:0] addr;
        logic [3:0]  be;
        kind = int'($unsigned($random(seed)) % 10);
        wr   = 1'($random(seed));
        be   = 4'($random(seed));
        case (kind)
            0, 1, 2, 3: begin
                // store words 0 to 63 under any region below hex c
                addr = {4'($unsigned($random(seed)) % 12), 16'($random(seed)), 4'd0,
                        6'($random(seed))};
            end
            4, 5: begin
                addr = {REGION_VMEM, 16'($random(seed)), 6'd0, 4'($random(seed))};
                be   = 4'b0001 << 2'($random(seed));
            end
            6: addr = {REGION_LOADER, 18'($random(seed)), 3'd0, 5'($random(seed))};
            7: begin
                if ($random(seed) & 1) begin
                    addr = {REGION_DEBUG, STATUS_TAG, 18'($unsigned($random(seed)) % 3)};
                end else begin
                    tag = 8'($random(seed));
                    if (tag == TRAP_TAG || tag == STATUS_TAG) begin
                        tag = 8'h40;
                    end
                    addr = {REGION_DEBUG, tag, 18'($random(seed))};
                end
            end
            8: addr = {REGION_DEBUG, TRAP_TAG, 18'($random(seed))};
            default: addr = {REGION_KBD, 26'($random(seed))};
        endcase
        if (kind == 8) begin
            hold_trap(wr, addr, 2 + int'($unsigned($random(seed)) % 4));
        end else begin
            run_access(wr, addr, 32'($random(seed)), be);
            if ($random(seed) & 1) begin
                idle_cycle();
            end
        end
    endtask

    initial begin
        seed          = SEED_INIT;
        timeout_count = 0;
        rst           = 1'b0;
        drive_cpu(1'b0, 1'b0, '0, '0, '0);
        instr_addr    = '0;
        for (int n = 0; n < 10; n++) begin
            @(negedge cache_stall);
        end
        rst = 1'b1;
        preload();
        for (int n = 0; n < RANDOM_OPS && timeout_count == 0; n++) begin
            random_access();
        end
        idle_cycle();
        for (int n = 0; n < 4; n++) begin
            @(negedge cache_stall);
        end
        $display("checks %0d, check errors %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (timeout_count != 0 || error_count != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/mmio_pkg.sv
verilog/mem_req_if.sv
verilog/bus_router.sv
verilog/text_mem.sv
verilog/loader_mem.sv
verilog/data_store.sv
verilog/trace_queue.sv
verilog/mmio_top.sv
test/mmio_checker.sv
test/tb_mmio.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mmio -f list.f \
    && ./obj_dir/Vtb_mmio | tee /dev/stderr | grep -q "^RESULT: PASS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
